//--- source/uart_apb_cfg.svh
`ifndef UART_APB_CFG_SVH
`define UART_APB_CFG_SVH

// Data path and APB bus widths
`define UART_DATA_W 8
`define UART_ADDR_W 7

// The FIFO count is one bit wider than the pointers
`define UART_FIFO_DEPTH 8
`define UART_FIFO_CNT_W 4

`define UART_REG_PRESCALE 0
`define UART_REG_COMMAND  1
`define UART_REG_STATUS   2
`define UART_REG_TRANSMIT 3
`define UART_REG_RECEIVE  4
`endif

//--- source/uart_apb_pkg.sv
`default_nettype none
`include "uart_apb_cfg.svh"

package uart_apb_pkg;

    typedef enum logic [`UART_ADDR_W-1:0] {
        REG_PRESCALE = `UART_REG_PRESCALE,
        REG_COMMAND  = `UART_REG_COMMAND,
        REG_STATUS   = `UART_REG_STATUS,
        REG_TRANSMIT = `UART_REG_TRANSMIT,
        REG_RECEIVE  = `UART_REG_RECEIVE
    } reg_addr_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    // Bit timing and enables shared by both serial blocks
    typedef struct packed {
        logic [7:0] prescale;
        logic       tx_enable;
        logic       rx_enable;
    } serial_cfg_t;

    typedef struct packed {
        logic                         full;
        logic                         empty;
        logic [`UART_FIFO_CNT_W-1:0] count;
    } fifo_status_t;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_apb_cfg.svh"

module sync_fifo
    import uart_apb_pkg::*;
(
    input  wire                     pclk,
    input  wire                     reset,
    input  wire                     clear,
    input  wire                     push,
    input  wire [`UART_DATA_W-1:0]  push_data,
    input  wire                     pop,
    output logic [`UART_DATA_W-1:0] pop_data,
    output fifo_status_t            status
);

    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);
    localparam logic [`UART_FIFO_CNT_W-1:0] DEPTH = `UART_FIFO_DEPTH;

    logic [`UART_DATA_W-1:0]     mem [`UART_FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [`UART_FIFO_CNT_W-1:0] count;
    logic                        do_push;
    logic                        do_pop;

    assign status.full  = (count == DEPTH);
    assign status.empty = (count == '0);
    assign status.count = count;

    // A push on full and a pop on empty are dropped
    assign do_push = push && !status.full;
    assign do_pop  = pop && !status.empty;

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge pclk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{(`UART_FIFO_CNT_W-1){1'b0}}, do_push}
                           - {{(`UART_FIFO_CNT_W-1){1'b0}}, do_pop};
        end
    end

    always_ff @(posedge pclk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    a_count_bound: assert property (@(posedge pclk) disable iff (reset) count <= DEPTH);
    a_ptr_count:   assert property (@(posedge pclk) disable iff (reset)
                                    wr_ptr - rd_ptr == count[PTR_W-1:0]);

endmodule

`default_nettype wire

//--- source/uart_serializer.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_apb_cfg.svh"

module uart_serializer
    import uart_apb_pkg::*;
(
    input  wire                    pclk,
    input  wire                    reset,
    input  wire serial_cfg_t       cfg,
    input  wire fifo_status_t      fifo_status,
    input  wire [`UART_DATA_W-1:0] fifo_data,
    output logic                   fifo_pop,
    output logic                   txd
);

    tx_state_e               state;
    logic [7:0]              cnt;
    logic [2:0]              bit_cnt;
    logic [`UART_DATA_W-1:0] shift;
    logic                    bit_end;

    // The enable is only looked at here, so a frame in flight always completes
    assign fifo_pop = (state == TX_IDLE) && cfg.tx_enable && !fifo_status.empty;
    assign bit_end  = (cnt == cfg.prescale);

    always_ff @(posedge pclk) begin
        if (reset) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            txd     <= 1'b1;
        end else begin
            cnt <= bit_end ? '0 : cnt + 8'd1;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    txd <= !fifo_pop;
                    if (fifo_pop) state <= TX_START;
                end
                TX_START: if (bit_end) begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                    txd     <= shift[0];
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    txd     <= (bit_cnt == 3'd7) ? 1'b1 : shift[1];
                    if (bit_cnt == 3'd7) state <= TX_STOP;
                end
                default: if (bit_end) state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (fifo_pop) shift <= fifo_data;
        else if (state == TX_DATA && bit_end) shift <= shift >> 1;
    end

    a_idle_high: assert property (@(posedge pclk) disable iff (reset)
                                  state == TX_IDLE |-> txd);

endmodule

`default_nettype wire

//--- source/uart_deserializer.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_apb_cfg.svh"

module uart_deserializer
    import uart_apb_pkg::*;
(
    input  wire                     pclk,
    input  wire                     reset,
    input  wire serial_cfg_t        cfg,
    input  wire                     rxd,
    output logic                    rx_valid,
    output logic [`UART_DATA_W-1:0] rx_data
);

    rx_state_e  state;
    logic       rxd_meta;
    logic       rxd_sync;
    logic       rxd_prev;
    logic [7:0] cnt;
    logic [2:0] bit_cnt;
    logic       bit_end;
    logic       half_bit;

    assign bit_end  = (cnt == cfg.prescale);
    assign half_bit = (cnt == {1'b0, cfg.prescale[7:1]});

    // ############################################################
    // Input synchronizer and edge detect
    // ############################################################
    always_ff @(posedge pclk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            cnt      <= bit_end ? '0 : cnt + 8'd1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (cfg.rx_enable && rxd_prev && !rxd_sync) state <= RX_START;
                end
                // From here on every sample lands mid-bit
                RX_START: if (half_bit) begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    state   <= rxd_sync ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                default: if (bit_end) begin
                    state    <= RX_IDLE;
                    rx_valid <= rxd_sync;
                end
            endcase
        end
    end

    // LSB arrives first, so bits enter at the top
    always_ff @(posedge pclk) begin
        if (state == RX_DATA && bit_end) rx_data <= {rxd_sync, rx_data[`UART_DATA_W-1:1]};
    end

    a_min_prescale: assert property (@(posedge pclk) disable iff (reset)
                                     cfg.rx_enable |-> cfg.prescale >= 8'd3);

endmodule

`default_nettype wire

//--- source/apb_uart_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_apb_cfg.svh"

module apb_uart_regs
    import uart_apb_pkg::*;
(
    input  wire                     pclk,
    input  wire                     reset,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire [`UART_ADDR_W-1:0]  paddr,
    input  wire [`UART_DATA_W-1:0]  pwdata,
    output logic [`UART_DATA_W-1:0] prdata,
    output logic                    pready,
    output serial_cfg_t             cfg,
    output logic                    fifo_clear,
    output logic                    tx_push,
    output logic [`UART_DATA_W-1:0] tx_data,
    input  wire fifo_status_t       tx_status,
    input  wire fifo_status_t       rx_status,
    output logic                    rx_pop,
    input  wire [`UART_DATA_W-1:0]  rx_head,
    input  wire                     rx_valid
);

    localparam logic [7:0] PRESCALE_RST = 8'd15;

    reg_addr_e addr;
    logic      access;
    logic      wr_en;
    logic      rd_en;
    logic      overrun;

    assign addr   = reg_addr_e'(paddr);
    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign rd_en  = access && !pwrite;

    // With zero wait states every access phase completes at once
    assign pready = access;

    // ############################################################
    // Strobes to the FIFOs
    // ############################################################
    assign fifo_clear = wr_en && (addr == REG_COMMAND) && pwdata[2];
    assign tx_push    = wr_en && (addr == REG_TRANSMIT);
    assign tx_data    = pwdata;
    assign rx_pop     = rd_en && (addr == REG_RECEIVE);

    always_ff @(posedge pclk) begin
        if (reset) begin
            cfg.prescale  <= PRESCALE_RST;
            cfg.tx_enable <= 1'b0;
            cfg.rx_enable <= 1'b0;
        end else if (wr_en) begin
            if (addr == REG_PRESCALE) cfg.prescale <= pwdata;
            if (addr == REG_COMMAND) begin
                cfg.tx_enable <= pwdata[0];
                cfg.rx_enable <= pwdata[1];
            end
        end
    end

    // Overrun stays set until a clear because the byte that caused it is lost
    always_ff @(posedge pclk) begin
        if (reset || fifo_clear) overrun <= 1'b0;
        else if (rx_valid && rx_status.full) overrun <= 1'b1;
    end

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (addr)
                REG_PRESCALE: prdata = cfg.prescale;
                REG_COMMAND:  prdata = {6'd0, cfg.rx_enable, cfg.tx_enable};
                REG_STATUS:   prdata = {3'd0, overrun, rx_status.empty, rx_status.full,
                                        tx_status.empty, tx_status.full};
                REG_RECEIVE:  prdata = rx_status.empty ? '0 : rx_head;
                default:      prdata = '0;
            endcase
        end
    end

    a_apb_phase: assert property (@(posedge pclk) disable iff (reset) penable |-> psel);

endmodule

`default_nettype wire

//--- source/uart_apb_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_apb_cfg.svh"

module uart_apb_top
    import uart_apb_pkg::*;
(
    input  wire                     pclk,
    input  wire                     reset,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire [`UART_ADDR_W-1:0]  paddr,
    input  wire [`UART_DATA_W-1:0]  pwdata,
    output logic [`UART_DATA_W-1:0] prdata,
    output logic                    pready,
    input  wire                     rxd,
    output logic                    txd
);

    serial_cfg_t             cfg;
    fifo_status_t            tx_status, rx_status;
    logic                    fifo_clear, tx_push, tx_pop, rx_pop, rx_valid;
    logic [`UART_DATA_W-1:0] tx_data, tx_head, rx_data, rx_head;

    apb_uart_regs regs (
        .pclk(pclk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .cfg(cfg),
        .fifo_clear(fifo_clear), .tx_push(tx_push), .tx_data(tx_data),
        .tx_status(tx_status), .rx_status(rx_status), .rx_pop(rx_pop),
        .rx_head(rx_head), .rx_valid(rx_valid)
    );

    // Transmit path
    sync_fifo tx_fifo (
        .pclk(pclk), .reset(reset), .clear(fifo_clear), .push(tx_push),
        .push_data(tx_data), .pop(tx_pop), .pop_data(tx_head), .status(tx_status)
    );
    uart_serializer serializer (
        .pclk(pclk), .reset(reset), .cfg(cfg), .fifo_status(tx_status),
        .fifo_data(tx_head), .fifo_pop(tx_pop), .txd(txd)
    );

    // Receive path
    uart_deserializer deserializer (
        .pclk(pclk), .reset(reset), .cfg(cfg), .rxd(rxd),
        .rx_valid(rx_valid), .rx_data(rx_data)
    );
    sync_fifo rx_fifo (
        .pclk(pclk), .reset(reset), .clear(fifo_clear), .push(rx_valid),
        .push_data(rx_data), .pop(rx_pop), .pop_data(rx_head), .status(rx_status)
    );

endmodule

`default_nettype wire

//--- tb/uart_apb_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_apb_cfg.svh"

module uart_apb_tb
    import uart_apb_pkg::*;
();

    localparam int PRESCALE     = 3;
    localparam int DEPTH        = `UART_FIFO_DEPTH;
    localparam int CYCLE_LIMIT  = 24 * 10 * (PRESCALE + 1) + 2000;
    localparam int FRAME_CYCLES = 10 * (PRESCALE + 1) + 1;

    logic                    pclk;
    logic                    reset;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`UART_ADDR_W-1:0] paddr;
    logic [`UART_DATA_W-1:0] pwdata;
    logic [`UART_DATA_W-1:0] prdata;
    logic                    pready;
    logic                    rxd;
    logic                    txd;
    logic                    loopback;
    logic [31:0]             seed;
    int                      cycles;
    int                      checks;
    int                      errors;
    int                      tests;
    logic [`UART_DATA_W-1:0] expected_q[$];

    uart_apb_top UUT (
        .pclk(pclk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .rxd(rxd), .txd(txd)
    );

    // The line idles high until reset is over, then txd drives rxd
    assign rxd = loopback ? txd : 1'b1;

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[23:16];
    endfunction

    // Builds the expected status word from the fill level of each FIFO
    function automatic logic [7:0] status_word(input int tx_cnt, input int rx_cnt,
                                               input logic ovr);
        return {3'd0, ovr, rx_cnt == 0, rx_cnt == DEPTH, tx_cnt == 0, tx_cnt == DEPTH};
    endfunction

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s expected 8'h%02h, got 8'h%02h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // ############################################################
    // APB master
    // ############################################################
    task automatic apb_write(input reg_addr_e addr, input logic [7:0] data);
        @(posedge pclk);
        psel   <= 1'b1;
        pwrite <= 1'b1;
        paddr  <= addr;
        pwdata <= data;
        @(posedge pclk);
        penable <= 1'b1;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input reg_addr_e addr, output logic [7:0] data);
        @(posedge pclk);
        psel   <= 1'b1;
        pwrite <= 1'b0;
        paddr  <= addr;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        data = prdata;
        check_value("pready", {7'd0, pready}, 8'd1);
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_expect(input reg_addr_e addr, input string name,
                               input logic [7:0] expected);
        logic [7:0] value;
        apb_read(addr, value);
        check_value(name, value, expected);
    endtask

    task automatic wait_status(input int bit_idx);
        logic [7:0] status;
        apb_read(REG_STATUS, status);
        while (!status[bit_idx]) apb_read(REG_STATUS, status);
    endtask

    task automatic drain_receive(input int count);
        for (int i = 0; i < count; i++) begin
            read_expect(REG_RECEIVE, "prdata(receive)", expected_q.pop_front());
        end
    endtask

    // Writes a byte whenever the transmit FIFO has room, and reads one back when asked
    task automatic stream(input int count, input logic drain);
        logic [7:0] status;
        logic [7:0] value;
        int         sent;
        int         got;
        sent = 0;
        got  = 0;
        while (sent < count || (drain && got < count)) begin
            apb_read(REG_STATUS, status);
            if (drain && !status[3]) begin
                read_expect(REG_RECEIVE, "prdata(receive)", expected_q.pop_front());
                got++;
            end else if (sent < count && !status[0]) begin
                value = next_rand();
                apb_write(REG_TRANSMIT, value);
                expected_q.push_back(value);
                sent++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) $display("test %0d %s: ok", tests, name);
        else $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    endtask

    initial begin
        int         mark;
        logic [7:0] value;
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        loopback = 1'b0;
        seed     = 32'h1330;
        cycles   = 0;
        checks   = 0;
        errors   = 0;
        tests    = 0;
        repeat (3) @(posedge pclk);
        reset    <= 1'b0;
        loopback <= 1'b1;

        mark = errors;
        @(negedge pclk);
        check_value("txd", {7'd0, txd}, 8'd1);
        check_value("pready", {7'd0, pready}, 8'd0);
        check_value("prdata", prdata, 8'd0);
        read_expect(REG_PRESCALE, "prdata(prescale)", 8'd15);
        read_expect(REG_COMMAND, "prdata(command)", 8'd0);
        read_expect(REG_STATUS, "prdata(status)", status_word(0, 0, 1'b0));
        read_expect(REG_RECEIVE, "prdata(receive)", 8'd0);
        finish_test("reset values", mark);

        mark  = errors;
        value = next_rand();
        apb_write(REG_PRESCALE, value);
        read_expect(REG_PRESCALE, "prdata(prescale)", value);
        apb_write(REG_COMMAND, 8'h05);
        read_expect(REG_COMMAND, "prdata(command)", 8'h01);
        apb_write(REG_COMMAND, 8'h00);
        finish_test("register access", mark);

        mark = errors;
        apb_write(REG_PRESCALE, 8'(PRESCALE));
        apb_write(REG_COMMAND, 8'h03);
        stream(16, 1'b1);
        read_expect(REG_STATUS, "prdata(status)", status_word(0, 0, 1'b0));
        finish_test("loopback of 16 bytes", mark);

        // Transmitter held off so the FIFO fills up
        mark = errors;
        apb_write(REG_COMMAND, 8'h02);
        for (int i = 0; i < DEPTH; i++) begin
            value = next_rand();
            apb_write(REG_TRANSMIT, value);
            expected_q.push_back(value);
        end
        read_expect(REG_STATUS, "prdata(status)", status_word(DEPTH, 0, 1'b0));
        apb_write(REG_TRANSMIT, next_rand());
        read_expect(REG_STATUS, "prdata(status)", status_word(DEPTH, 0, 1'b0));
        apb_write(REG_COMMAND, 8'h03);
        wait_status(2);
        read_expect(REG_STATUS, "prdata(status)", status_word(0, DEPTH, 1'b0));
        drain_receive(DEPTH);
        // A ninth byte that got through would land within one more frame
        repeat (FRAME_CYCLES) @(posedge pclk);
        read_expect(REG_STATUS, "prdata(status)", status_word(0, 0, 1'b0));
        finish_test("transmit back-pressure", mark);

        mark = errors;
        stream(DEPTH + 1, 1'b0);
        wait_status(4);
        read_expect(REG_STATUS, "prdata(status)", status_word(0, DEPTH, 1'b1));
        drain_receive(DEPTH);
        expected_q.delete();
        read_expect(REG_STATUS, "prdata(status)", status_word(0, 0, 1'b1));
        apb_write(REG_COMMAND, 8'h07);
        read_expect(REG_STATUS, "prdata(status)", status_word(0, 0, 1'b0));
        read_expect(REG_COMMAND, "prdata(command)", 8'h03);
        finish_test("receive overrun", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/uart_apb_pkg.sv
source/sync_fifo.sv
source/uart_serializer.sv
source/uart_deserializer.sv
source/apb_uart_regs.sv
source/uart_apb_top.sv
tb/uart_apb_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = uart_apb_tb
FLIST = flist.f

.PHONY: sim clean

# The run passes only when the testbench prints the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
